// ==== hdl/spi_frame_engine.sv ====
`timescale 1ns/1ps

module spi_frame_engine (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              tx_en,
	input  logic                              rx_en,
	input  logic                              mode_select,  // 1 selects idle-high SCLK, late data
	input  logic                              start_done,
	input  logic                              gap_busy,
	input  logic                              run_done,
	input  logic [spi_test_pkg::IDX_W-1:0]    frame_index,  // Byte to send this frame
	input  logic                              spi_miso,
	output logic                              spi_clk,
	output logic                              spi_mosi,
	output logic                              cs,
	output logic                              frame_end,    // Pulse on the last step
	output logic [spi_test_pkg::BYTE_W-1:0]   rx_byte       // Valid with frame_end
);

	typedef logic [spi_test_pkg::STEP_W-1:0] step_t;
	typedef logic [spi_test_pkg::STEP_W-2:0] phase_t;  // Step count in bit phases
	typedef logic [spi_test_pkg::BYTE_W-1:0] byte_t;

	step_t  step;        // Position inside the current frame
	step_t  frame_len;   // Last step for the selected mode
	step_t  sclk_start;  // SCLK toggles only above this step
	phase_t ph0;         // Bit phase as seen by mode 0
	phase_t ph1;         // Same phase one bit later for mode 1
	phase_t tx_ph;       // Phase that picks the MOSI bit
	byte_t  tx_byte;
	byte_t  rx_m0;       // MISO capture on mode 0 sample steps
	byte_t  rx_m1;       // MISO capture on mode 1 sample steps
	logic   run_ok;

	// The one place that decides whether a frame may advance
	assign run_ok = (tx_en || rx_en) && start_done && !gap_busy && !run_done;

	// Mode dependent frame shape
	assign frame_len  = mode_select ? step_t'(spi_test_pkg::MODE1_LEN)
	                                : step_t'(spi_test_pkg::MODE0_LEN);
	assign sclk_start = mode_select ? step_t'(spi_test_pkg::MODE1_OFFSET) : '0;

	// >= keeps a mode switch mid-frame from running past the end
	assign frame_end = run_ok && (step >= frame_len);

	// Step counter and chip select
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			step <= '0;
			cs   <= 1'b1;
		end else if (run_ok && !frame_end) begin
			step <= step + 1'b1;
			cs   <= 1'b0;          // Low from the first step on
		end else begin
			// Frame done, abandoned, or waiting on gap or start delay
			step <= '0;
			cs   <= 1'b1;
		end
	end

	// SCLK
	// 16 toggles per frame give 8 full pulses and end at the idle level
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			spi_clk <= mode_select;  // Idle level follows the mode
		end else if (!run_ok) begin
			spi_clk <= mode_select;  // Abandoned frame snaps back to idle
		end else if ((step > sclk_start) && (step < frame_len)) begin
			spi_clk <= ~spi_clk;
		end
	end

	// Bit phases change every two steps
	assign ph0   = step[spi_test_pkg::STEP_W-1:1];
	assign ph1   = ph0 - 1'b1;            // Wraps out of range on phase 0
	assign tx_ph = mode_select ? ph1 : ph0;

	assign tx_byte = frame_index[spi_test_pkg::BYTE_W-1:0];  // Frame n carries byte n

	// MOSI
	// MSB first, line parked high outside the data phases
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			spi_mosi <= 1'b1;
		end else if (tx_en && run_ok && (tx_ph < phase_t'(spi_test_pkg::BYTE_W))) begin
			spi_mosi <= tx_byte[spi_test_pkg::BYTE_W - 1 - int'(tx_ph)];
		end else begin
			spi_mosi <= 1'b1;  // Also covers tx disabled
		end
	end

	// MISO capture on odd steps
	// Both phase registers fill in parallel, mode picks one at frame end
	always_ff @(posedge clk) begin
		if (run_ok && rx_en && step[0]) begin
			if (ph0 < phase_t'(spi_test_pkg::BYTE_W)) begin
				rx_m0[spi_test_pkg::BYTE_W - 1 - int'(ph0)] <= spi_miso;  // Steps 1 to 15
			end
			if (ph1 < phase_t'(spi_test_pkg::BYTE_W)) begin
				rx_m1[spi_test_pkg::BYTE_W - 1 - int'(ph1)] <= spi_miso;  // Steps 3 to 17
			end
		end
	end

	// Last sample lands before the final step in both modes
	assign rx_byte = mode_select ? rx_m1 : rx_m0;

endmodule

// ==== hdl/spi_launch_timer.sv ====
`timescale 1ns/1ps

module spi_launch_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic tx_en,
	input  logic rx_en,
	input  logic frame_end,   // One-cycle pulse at the close of every frame
	output logic start_done,  // Sticky level once the start delay has elapsed
	output logic gap_busy     // High while the inter-frame gap runs
);

	// Counters sized to hold their full delay value
	typedef logic [$clog2(spi_test_pkg::START_DELAY + 1)-1:0] start_cnt_t;
	typedef logic [$clog2(spi_test_pkg::FRAME_GAP + 1)-1:0] gap_cnt_t;

	start_cnt_t start_cnt;  // Enabled cycles seen so far
	gap_cnt_t   gap_cnt;    // Remaining gap cycles

	// Start delay
	// Only cycles with an enable count, so a paused enable pauses the delay
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			start_cnt  <= '0;
			start_done <= 1'b0;
		end else if ((tx_en || rx_en) && !start_done) begin
			start_cnt <= start_cnt + 1'b1;
			if (start_cnt == start_cnt_t'(spi_test_pkg::START_DELAY - 1)) begin
				start_done <= 1'b1;  // Rises START_DELAY cycles after first enable
			end
		end
	end

	// Inter-frame gap
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			gap_cnt <= '0;
		end else if (frame_end) begin
			gap_cnt <= gap_cnt_t'(spi_test_pkg::FRAME_GAP);  // Reload on every frame end
		end else if (gap_cnt != '0) begin
			gap_cnt <= gap_cnt - 1'b1;
		end
	end

	// Busy for exactly FRAME_GAP cycles after each frame_end
	assign gap_busy = (gap_cnt != '0);

endmodule

// ==== hdl/spi_rx_verifier.sv ====
`timescale 1ns/1ps

module spi_rx_verifier (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              rx_en,
	input  logic                              frame_end,       // Closes one frame
	input  logic [spi_test_pkg::BYTE_W-1:0]   rx_byte,         // Byte captured from MISO
	output logic [spi_test_pkg::IDX_W-1:0]    frame_index,     // Frames completed so far
	output logic                              run_done,        // Stops the engine
	output logic                              spi_over,        // Done level at the pins
	output logic                              receive_status   // Pass level at the pins
);

	typedef logic [spi_test_pkg::IDX_W-1:0] idx_t;

	idx_t match_cnt;   // Frames whose byte matched the index
	logic rx_match;
	logic last_frame;
	logic done_q;

	// Expected byte is the index of the frame that just ended
	assign rx_match   = rx_en && (rx_byte == frame_index[spi_test_pkg::BYTE_W-1:0]);
	assign last_frame = (frame_index == idx_t'(spi_test_pkg::FRAME_COUNT - 1));

	// Frame index
	// An abandoned frame has no frame_end so the index holds and it repeats
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			frame_index <= '0;
		end else if (frame_end) begin
			frame_index <= frame_index + 1'b1;
		end
	end

	// Match counter
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			match_cnt <= '0;
		end else if (frame_end && rx_match) begin
			match_cnt <= match_cnt + 1'b1;  // Only counts while rx is enabled
		end
	end

	// Done flag
	// Set on the edge that ends the last frame so it shows one cycle later
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done_q <= 1'b0;
		end else if (frame_end && last_frame) begin
			done_q <= 1'b1;
		end
	end

	// Pass level trails done by one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			receive_status <= 1'b0;
		end else begin
			receive_status <= done_q && (match_cnt == idx_t'(spi_test_pkg::FRAME_COUNT));
		end
	end

	assign run_done = done_q;
	assign spi_over = done_q;  // Same level, one for the engine and one for the pins

endmodule

// ==== hdl/spi_test_master.sv ====
`timescale 1ns/1ps

module spi_test_master (
	input  logic clk,
	input  logic rst_n,
	input  logic tx_en,           // Drive the index byte on MOSI
	input  logic rx_en,           // Check MISO against the index byte
	input  logic mode_select,     // 0 idle-low SCLK, 1 idle-high with late data
	input  logic spi_miso,
	output logic spi_mosi,
	output logic spi_clk,
	output logic cs,
	output logic spi_over,        // All frames sent
	output logic receive_status   // All received bytes matched
);

	// Timer to engine
	logic start_done;
	logic gap_busy;

	// Engine to timer and verifier
	logic                            frame_end;
	logic [spi_test_pkg::BYTE_W-1:0] rx_byte;

	// Verifier to engine
	logic [spi_test_pkg::IDX_W-1:0]  frame_index;
	logic                            run_done;

	// Start delay and inter-frame gap
	spi_launch_timer u_timer (
		.clk        (clk),
		.rst_n      (rst_n),
		.tx_en      (tx_en),
		.rx_en      (rx_en),
		.frame_end  (frame_end),
		.start_done (start_done),
		.gap_busy   (gap_busy)
	);

	// Pin timing for both clock modes
	spi_frame_engine u_engine (
		.clk         (clk),
		.rst_n       (rst_n),
		.tx_en       (tx_en),
		.rx_en       (rx_en),
		.mode_select (mode_select),
		.start_done  (start_done),
		.gap_busy    (gap_busy),
		.run_done    (run_done),
		.frame_index (frame_index),
		.spi_miso    (spi_miso),
		.spi_clk     (spi_clk),
		.spi_mosi    (spi_mosi),
		.cs          (cs),
		.frame_end   (frame_end),
		.rx_byte     (rx_byte)
	);

	// Frame bookkeeping and pass or fail result
	spi_rx_verifier u_verifier (
		.clk            (clk),
		.rst_n          (rst_n),
		.rx_en          (rx_en),
		.frame_end      (frame_end),
		.rx_byte        (rx_byte),
		.frame_index    (frame_index),
		.run_done       (run_done),
		.spi_over       (spi_over),
		.receive_status (receive_status)
	);

endmodule

// ==== hdl/spi_test_pkg.sv ====
package spi_test_pkg;

	// Run length and byte size
	localparam int FRAME_COUNT = 64;   // Frames per self-test run
	localparam int BYTE_W      = 8;    // Payload bits per frame
	localparam int IDX_W       = 8;    // Frame index width, also the MOSI byte source

	// Delays in clk cycles
	localparam int START_DELAY = 250;  // Enabled cycles before the first frame
	localparam int FRAME_GAP   = 250;  // Idle cycles with cs high between frames

	// Frame step counter
	localparam int STEP_W = 5;         // Wide enough for the longest frame

	// Mode 0 has SCLK idle low and data on the first bit phase
	localparam int MODE0_LEN = 17;     // Step count that closes a mode 0 frame

	// Mode 1 has SCLK idle high and data one bit phase late
	localparam int MODE1_LEN    = 18;  // Step count that closes a mode 1 frame
	localparam int MODE1_OFFSET = 1;   // SCLK starts toggling after this step

endpackage

// ==== spi_test_master.f ====
hdl/spi_test_pkg.sv
hdl/spi_launch_timer.sv
hdl/spi_frame_engine.sv
hdl/spi_rx_verifier.sv
hdl/spi_test_master.sv
verif/tb_clk_gen.sv
verif/spi_slave_model.sv
verif/spi_test_checker.sv
verif/tb_spi_test_master.sv

// ==== verif/spi_slave_model.sv ====
`timescale 1ns/1ps

module spi_slave_model (
	input  logic       rst_n,
	input  logic       mode_select,    // Same clock mode as the DUT
	input  logic       cs,
	input  logic       spi_clk,
	input  logic       corrupt_en,     // Turns the fault on
	input  logic [7:0] corrupt_frame,  // Frame whose reply gets bit 0 flipped
	output logic       spi_miso
);

	logic [7:0] frame_cnt;  // Complete frames seen, also the next reply byte
	logic [7:0] tx_sh;      // Reply for the current frame
	int         n_in;
	int         n_out;

	initial begin
		spi_miso  = 1'b1;
		frame_cnt = '0;
		forever begin
			@(negedge cs or negedge rst_n);
			if (!rst_n) begin
				frame_cnt = '0;
			end else begin
				tx_sh = frame_cnt;
				if (corrupt_en && (frame_cnt == corrupt_frame)) begin
					tx_sh[0] = ~tx_sh[0];  // Injected fault
				end
				n_in  = 0;
				n_out = 0;
				if (!mode_select) begin
					spi_miso = tx_sh[7];  // Mode 0 needs bit 7 before the first rising edge
					n_out    = 1;
				end
				while (cs === 1'b0) begin
					@(posedge spi_clk or negedge spi_clk or posedge cs);
					if ((cs === 1'b0) && (spi_clk === 1'b1)) begin
						n_in++;                         // One bit clocked in on rising SCLK
					end else if ((cs === 1'b0) && (n_out < 8)) begin
						spi_miso = tx_sh[7 - n_out];    // Next bit on falling SCLK
						n_out++;
					end
				end
				// Abandoned frames are not counted
				if (n_in == 8) frame_cnt++;
			end
		end
	end

endmodule

// ==== verif/spi_test_checker.sv ====
`timescale 1ns/1ps

module spi_test_checker (
	input logic clk,
	input logic rst_n,
	input logic cs,
	input logic spi_clk,
	input logic spi_mosi,
	input logic spi_over,
	input logic receive_status
);

	logic [7:0] captured[$];    // Every complete MOSI byte since time zero
	string      test_name;
	logic       cfg_tx = 1'b1;
	logic       cfg_rx = 1'b0;
	logic       cfg_fault = 1'b0;
	int         base;           // Queue slot of this test's first frame
	int         test_errors;
	logic       over_q;
	logic       watch;          // Set for the cycle right after spi_over rose
	logic       status_next;
	logic       status_early;   // receive_status seen before spi_over had been high a cycle
	logic       mosi_low;       // MOSI low while tx was off
	int         over_rises;

	// Frame n carries byte n and a line with tx off reads all ones
	function automatic void predict_result(
		input  logic       tx,
		input  logic       rx,
		input  logic       fault,
		input  int         n,
		output logic [7:0] exp_byte,
		output logic       exp_over,
		output logic       exp_status
	);
		exp_byte   = tx ? n[7:0] : 8'hff;
		exp_over   = 1'b1;            // Every enable mix runs all frames
		exp_status = rx && !fault;    // Needs the compare on and no bad reply
	endfunction

	// MOSI capture on rising SCLK, byte stored when cs rises
	initial begin : capture
		logic [7:0] sh;
		int         nbits;
		forever begin
			@(negedge cs);
			nbits = 0;
			sh    = '1;
			while (cs === 1'b0) begin
				@(posedge spi_clk or posedge cs);
				if ((cs === 1'b0) && (spi_clk === 1'b1)) begin
					sh = {sh[6:0], spi_mosi};
					nbits++;
				end
			end
			if (nbits == 8) captured.push_back(sh);  // Partial frames drop out
		end
	end

	// Result levels sampled on every edge
	always @(posedge clk) begin
		if (!rst_n) begin
			over_q       <= 1'b0;
			watch        <= 1'b0;
			status_next  <= 1'b0;
			status_early <= 1'b0;
			mosi_low     <= 1'b0;
			over_rises   <= 0;
		end else begin
			over_q <= spi_over;
			watch  <= spi_over && !over_q;
			if (spi_over && !over_q) over_rises <= over_rises + 1;
			if (watch) status_next <= receive_status;
			if (receive_status && !(spi_over && over_q)) status_early <= 1'b1;
			if (!cfg_tx && (spi_mosi === 1'b0)) mosi_low <= 1'b1;
		end
	end

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s %s: expected 0x%0h, actual 0x%0h",
				test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name, input logic tx, input logic rx,
		input logic fault);
		test_name   = name;
		cfg_tx      = tx;
		cfg_rx      = rx;
		cfg_fault   = fault;
		base        = captured.size();
		test_errors = 0;
	endtask

	task automatic check_idle(input logic mode);
		check_value("idle cs", 1, cs);
		check_value("idle mosi", 1, spi_mosi);
		check_value("idle sclk", mode, spi_clk);  // Idle level follows the mode
		check_value("idle spi_over", 0, spi_over);
		check_value("idle receive_status", 0, receive_status);
	endtask

	task automatic report_test(output int errs);
		errs = test_errors;
		$display("test %s: %s, %0d errors", test_name, (errs == 0) ? "ok" : "FAILED", errs);
	endtask

	task automatic end_test(output int errs);
		logic [7:0] exp_byte;
		logic       exp_over;
		logic       exp_status;
		int         got;
		got = captured.size() - base;
		check_value("frame count", spi_test_pkg::FRAME_COUNT, got);
		for (int n = 0; (n < spi_test_pkg::FRAME_COUNT) && (n < got); n++) begin
			predict_result(cfg_tx, cfg_rx, cfg_fault, n, exp_byte, exp_over, exp_status);
			check_value($sformatf("mosi byte %0d", n), exp_byte, captured[base + n]);
		end
		predict_result(cfg_tx, cfg_rx, cfg_fault, 0, exp_byte, exp_over, exp_status);
		check_value("spi_over", exp_over, spi_over);
		check_value("spi_over rises", 1, over_rises);
		check_value("receive_status after spi_over", exp_status, status_next);
		check_value("receive_status", exp_status, receive_status);
		if (status_early) begin
			$display("%s: receive_status did not trail spi_over by one cycle", test_name);
			test_errors++;
		end
		if (mosi_low) begin
			$display("%s: MOSI went low while transmit was disabled", test_name);
			test_errors++;
		end
		report_test(errs);
	endtask

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	input  logic restart,  // Rising edge starts a fresh reset pulse
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD  = 4;  // 8 ns clock
	localparam int RESET_CYCLES = 5;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Reset at time zero, then again on every restart request
	initial begin
		rst_n = 1'b0;
		forever begin
			repeat (RESET_CYCLES) @(posedge clk);
			#1 rst_n = 1'b1;  // Released just after an edge like the other inputs
			@(posedge restart);
			rst_n = 1'b0;
		end
	end

endmodule

// ==== verif/tb_spi_test_master.sv ====
`timescale 1ns/1ps

module tb_spi_test_master;

	localparam int LFSR_W      = 16;
	localparam int RESET_LIMIT = 50;     // Cycles to leave reset
	localparam int RUN_LIMIT   = 25000;  // Cycles for a full run of 64 frames
	localparam int CS_LIMIT    = 1000;   // Cycles for one cs change

	logic              clk;
	logic              rst_n;
	logic              restart;
	logic              tx_en;
	logic              rx_en;
	logic              mode_select;
	logic              spi_miso;
	logic              spi_mosi;
	logic              spi_clk;
	logic              cs;
	logic              spi_over;
	logic              receive_status;
	logic              corrupt_en;
	logic [7:0]        corrupt_frame;
	logic [LFSR_W-1:0] lfsr;
	int                tests_run;
	int                tests_failed;
	int                check_errors;

	tb_clk_gen clk_gen_i (.restart(restart), .clk(clk), .rst_n(rst_n));

	spi_test_master dut_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.tx_en          (tx_en),
		.rx_en          (rx_en),
		.mode_select    (mode_select),
		.spi_miso       (spi_miso),
		.spi_mosi       (spi_mosi),
		.spi_clk        (spi_clk),
		.cs             (cs),
		.spi_over       (spi_over),
		.receive_status (receive_status)
	);

	spi_slave_model slave_i (
		.rst_n         (rst_n),
		.mode_select   (mode_select),
		.cs            (cs),
		.spi_clk       (spi_clk),
		.corrupt_en    (corrupt_en),
		.corrupt_frame (corrupt_frame),
		.spi_miso      (spi_miso)
	);

	spi_test_checker chk_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.cs             (cs),
		.spi_clk        (spi_clk),
		.spi_mosi       (spi_mosi),
		.spi_over       (spi_over),
		.receive_status (receive_status)
	);

	// Right-shifting Fibonacci LFSR for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [LFSR_W-1:0] lfsr_step(input logic [LFSR_W-1:0] s);
		return {s[0] ^ s[2] ^ s[3] ^ s[5], s[LFSR_W-1:1]};
	endfunction

	task automatic draw_random(input int nbits, output int value);
		value = 0;
		for (int i = 0; i < nbits; i++) begin
			lfsr  = lfsr_step(lfsr);         // One step per bit taken
			value = (value << 1) | lfsr[LFSR_W-1];
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Test failed");
		$finish;
	endtask

	// Loops sample at the edge and return 1 ns after it
	task automatic wait_reset();
		int cnt;
		cnt = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk);
			cnt++;
			if (cnt > RESET_LIMIT) fail_timeout("reset release");
		end
		#1;
	endtask

	task automatic wait_over();
		int cnt;
		cnt = 0;
		while (spi_over !== 1'b1) begin
			@(posedge clk);
			cnt++;
			if (cnt > RUN_LIMIT) fail_timeout("spi_over");
		end
		#1;
	endtask

	task automatic wait_cs(input logic level);
		int cnt;
		cnt = 0;
		while (cs !== level) begin
			@(posedge clk);
			cnt++;
			if (cnt > CS_LIMIT) fail_timeout("chip select");
		end
		#1;
	endtask

	task automatic tally(input int errs);
		tests_run++;
		if (errs != 0) tests_failed++;
		check_errors += errs;
	endtask

	// Reset with the new settings, check idle pins, then enable
	task automatic start_case(input string name, input logic mode, input logic tx,
		input logic rx, input logic fault);
		tx_en       = 1'b0;
		rx_en       = 1'b0;
		mode_select = mode;
		corrupt_en  = fault;
		restart     = 1'b1;
		@(posedge clk);
		#1 restart  = 1'b0;
		wait_reset();
		chk_i.begin_test(name, tx, rx, fault);
		chk_i.check_idle(mode);
		tx_en = tx;
		rx_en = rx;
	endtask

	task automatic finish_case();
		int errs;
		wait_over();
		repeat (3) @(posedge clk);  // Lets receive_status settle after spi_over
		#1;
		chk_i.end_test(errs);
		tally(errs);
	endtask

	initial begin : main
		int frame;
		int errs;
		restart       = 1'b0;
		tx_en         = 1'b0;
		rx_en         = 1'b0;
		mode_select   = 1'b0;
		corrupt_en    = 1'b0;
		corrupt_frame = '0;
		lfsr          = 1;
		tests_run     = 0;
		tests_failed  = 0;
		check_errors  = 0;
		wait_reset();

		start_case("reset_idle", 1'b0, 1'b0, 1'b0, 1'b0);
		chk_i.report_test(errs);
		tally(errs);

		start_case("full_duplex_mode0", 1'b0, 1'b1, 1'b1, 1'b0);
		finish_case();
		start_case("full_duplex_mode1", 1'b1, 1'b1, 1'b1, 1'b0);
		finish_case();

		draw_random(6, frame);          // Any of the 64 frames
		corrupt_frame = frame[7:0];
		$display("fault injected in frame %0d", frame);
		start_case("fault_injection", 1'b0, 1'b1, 1'b1, 1'b1);
		finish_case();

		start_case("tx_only", 1'b0, 1'b1, 1'b0, 1'b0);
		finish_case();
		start_case("rx_only", 1'b0, 1'b0, 1'b1, 1'b0);
		finish_case();

		// Let 20 frames pass, then drop both enables early in the next one
		start_case("pause_resume", 1'b0, 1'b1, 1'b1, 1'b0);
		repeat (20) begin
			wait_cs(1'b0);
			wait_cs(1'b1);
		end
		wait_cs(1'b0);
		repeat (4) @(posedge clk);
		#1;
		tx_en = 1'b0;
		rx_en = 1'b0;
		repeat (100) @(posedge clk);
		#1;
		tx_en = 1'b1;  // Abandoned frame is sent again
		rx_en = 1'b1;
		finish_case();

		$display("%0d tests run, %0d failed, %0d check errors",
			tests_run, tests_failed, check_errors);
		if (tests_failed == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
